/* verilog.f */
+incdir+hdl
+incdir+bench
hdl/LsuOpPkg.sv
hdl/SpecPkg.sv
hdl/DataMemory.sv
hdl/LoadBuffer.sv
hdl/LSU.sv
hdl/LoadStoreUnit.sv
bench/LoadStoreUnitTb.sv

/* bench/lsuModel.svh */
`ifndef LSU_MODEL_SVH
`define LSU_MODEL_SVH

// Each stage holds what the matching DUT register holds after a clock edge.
logic [31:0] modelMem [`MEM_WORDS];

logic        midValid, resValid, resMisp, redirValid;
LsuOp        midOp, resOp;
Tag          midTag, resTag;
RegName      midNm, resNm;
SqN          midSqN, resSqN, redirSqN;
logic [31:0] midAddr, midData, midPc, resData, resPc, redirPc;

logic        tblValid [`LB_DEPTH];
logic [29:0] tblWord [`LB_DEPTH];
SqN          tblSqN [`LB_DEPTH];

// Signed 6-bit distance a - r is zero or negative.
function automatic logic ageNotAfter(input SqN a, input SqN r);
    logic [5:0] d;
    d = a - r;
    return (d == 6'd0) || d[5];
endfunction

function automatic logic ageBefore(input SqN a, input SqN r);
    logic [5:0] d;
    d = a - r;
    return (d != 6'd0) && d[5];
endfunction

function automatic logic survives(input SqN s);
    return !invalidate || ageNotAfter(s, invalidateSqN);
endfunction

function automatic logic writesMemory(input LsuOp op);
    case (op)
        LSU_SB, LSU_SH, LSU_SW: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

function automatic int wordIndex(input logic [31:0] addr);
    return int'((addr >> 2) % `MEM_WORDS);
endfunction

function automatic logic [31:0] loadValue(input LsuOp op, input logic [31:0] addr);
    logic [31:0] word;
    logic [7:0]  b;
    logic [15:0] h;
    word = modelMem[wordIndex(addr)];
    b = 8'(word >> (8 * addr[1:0]));
    h = addr[1] ? word[31:16] : word[15:0];
    case (op)
        LSU_LB:  return {{24{b[7]}}, b};
        LSU_LBU: return {24'h0, b};
        LSU_LH:  return {{16{h[15]}}, h};
        LSU_LHU: return {16'h0, h};
        default: return word;
    endcase
endfunction

task automatic storeToMemory(input LsuOp op, input logic [31:0] addr, input logic [31:0] d);
    int w;
    w = wordIndex(addr);
    case (op)
        LSU_SB:  modelMem[w][8 * addr[1:0] +: 8] = d[7:0];
        LSU_SH:  modelMem[w][16 * addr[1] +: 16] = d[15:0];
        default: modelMem[w] = d;
    endcase
endtask

task automatic resetModel();
    midValid = 1'b0;
    resValid = 1'b0;
    resMisp = 1'b0;
    redirValid = 1'b0;
    for (int i = 0; i < `LB_DEPTH; i++)
        tblValid[i] = 1'b0;
    for (int i = 0; i < `MEM_WORDS; i++)
        modelMem[i] = 32'h0;
endtask

// One rising edge, using the inputs that were driven before it.
task automatic advanceModel();
    logic keepIn, keepMid, keepOut, hit;
    int used, freeSlot;
    keepOut = resValid && survives(resSqN);
    keepMid = midValid && survives(midSqN);
    keepIn = inValid && survives(sqN);
    redirValid = keepOut && resMisp;
    if (keepOut) begin
        redirPc = resPc + 32'd4;
        redirSqN = resSqN;
    end
    hit = 1'b0;
    used = 0;
    freeSlot = 0;
    for (int i = `LB_DEPTH - 1; i >= 0; i--) begin
        if (tblValid[i]) begin
            used++;
            if (tblWord[i] == midAddr[31:2] && ageBefore(midSqN, tblSqN[i]))
                hit = 1'b1;
        end else begin
            freeSlot = i;
        end
    end
    resMisp = midValid && writesMemory(midOp) && hit;
    for (int i = 0; i < `LB_DEPTH; i++) begin
        if ((invalidate && !ageNotAfter(tblSqN[i], invalidateSqN))
                || (commitValid && ageNotAfter(tblSqN[i], commitSqN)))
            tblValid[i] = 1'b0;
    end
    if (midValid && !writesMemory(midOp)) begin
        if (used == `LB_DEPTH)
            abortRun("load table overflowed, a load arrived with every entry in use");
        tblValid[freeSlot] = 1'b1;
        tblWord[freeSlot] = midAddr[31:2];
        tblSqN[freeSlot] = midSqN;
    end
    if (midValid && writesMemory(midOp))
        storeToMemory(midOp, midAddr, midData); // Flush in stage two is too late.
    resValid = keepMid;
    if (keepMid) begin
        resOp = midOp;
        resTag = midTag;
        resNm = midNm;
        resSqN = midSqN;
        resPc = midPc;
        resData = loadValue(midOp, midAddr);
    end
    midValid = keepIn;
    if (keepIn) begin
        midOp = opcode;
        midTag = tagDst;
        midNm = nmDst;
        midSqN = sqN;
        midPc = pc;
        midAddr = srcA + imm;
        midData = srcB;
    end
endtask

`endif

/* bench/LoadStoreUnitTb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "lsu_settings.svh"

module LoadStoreUnitTb import LsuOpPkg::*, SpecPkg::*; ();

    logic        clk, rst;
    logic        inValid, invalidate, commitValid;
    LsuOp        opcode;
    logic [31:0] srcA, srcB, imm, pc;
    Tag          tagDst;
    RegName      nmDst;
    SqN          sqN, invalidateSqN, commitSqN;

    logic        outValid, branchTaken, wbReq;
    Tag          outTagDst;
    RegName      outNmDst;
    SqN          outSqN, branchSqN;
    logic [31:0] outResult, branchDstPc;

    logic [31:0] rngState;
    SqN          seqHead;
    int          loadsSeen, redirectsSeen;
    logic        drained;

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic abortRun(input string reason);
        $display("Error: %s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "run aborted");
    endtask

    `include "lsuModel.svh"

    LoadStoreUnit LoadStoreUnit_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] nextRand();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    task automatic driveRandom(input logic allBusy);
        int used;
        logic [31:0] r;
        used = (midValid && !writesMemory(midOp)) ? 1 : 0;
        for (int i = 0; i < `LB_DEPTH; i++)
            used += tblValid[i];
        r = nextRand();
        inValid = allBusy || (r[1:0] != 2'b00);
        opcode = LsuOp'(6'(nextRand() % 8));
        if (used > 5)
            opcode = LsuOp'(6'(5 + nextRand() % 3)); // Table nearly full so only stores issue.
        srcA = 32'h1000 + (nextRand() & 32'hF8); // 64-word window.
        imm = nextRand() & 32'h7;
        srcB = nextRand();
        tagDst = Tag'(nextRand());
        nmDst = RegName'(nextRand());
        pc = nextRand() & ~32'h3;
        seqHead = seqHead + SqN'(1);
        sqN = seqHead - SqN'(nextRand() % 8);
        invalidate = (r[5:2] == 4'h0);
        invalidateSqN = seqHead - SqN'(nextRand() % 8);
        commitValid = (r[7:6] == 2'b00) || (used > 3);
        commitSqN = (used > 3) ? seqHead : seqHead - SqN'(nextRand() % 8);
    endtask

    task automatic compareOutputs();
        checkValue("outValid", 32'(resValid), 32'(outValid));
        checkValue("wbReq", 32'(midValid && survives(midSqN)), 32'(wbReq));
        checkValue("branchTaken", 32'(redirValid), 32'(branchTaken));
        if (resValid) begin
            checkValue("outTagDst", 32'(resTag), 32'(outTagDst));
            checkValue("outNmDst", 32'(resNm), 32'(outNmDst));
            checkValue("outSqN", 32'(resSqN), 32'(outSqN));
            if (!writesMemory(resOp)) begin
                checkValue("outResult", resData, outResult);
                loadsSeen++;
            end
        end
        if (redirValid) begin
            checkValue("branchDstPc", redirPc, branchDstPc);
            checkValue("branchSqN", 32'(redirSqN), 32'(branchSqN));
            redirectsSeen++;
        end
    endtask

    task automatic runCycle(input logic active, input logic allBusy);
        @(negedge clk);
        advanceModel();
        if (active) begin
            driveRandom(allBusy);
        end else begin
            inValid = 1'b0;
            invalidate = 1'b0;
            commitValid = 1'b0;
        end
        #1;
        compareOutputs();
    endtask

    initial begin
        rst = 1'b1;
        inValid = 1'b0;
        opcode = LSU_LW;
        srcA = '0;
        srcB = '0;
        imm = '0;
        pc = '0;
        tagDst = '0;
        nmDst = '0;
        sqN = '0;
        invalidate = 1'b0;
        invalidateSqN = '0;
        commitValid = 1'b0;
        commitSqN = '0;
        rngState = 32'h386b;
        seqHead = '0;
        loadsSeen = 0;
        redirectsSeen = 0;
        resetModel();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        compareOutputs(); // Outputs idle straight out of reset.
        for (int c = 0; c < 4000; c++)
            runCycle(1'b1, c < 300);
        drained = 1'b0;
        for (int c = 0; c < 8 && !drained; c++) begin
            runCycle(1'b0, 1'b0);
            drained = !midValid && !resValid && !redirValid;
        end
        if (!drained) begin
            abortRun("pipeline did not drain after the last micro-op");
        end else begin
            for (int w = 0; w < 64; w++)
                checkValue($sformatf("mem[%0d]", w), modelMem[w],
                           LoadStoreUnit_inst.DataMemory_inst.mem[w]);
            $display("Checked %0d load results and %0d redirects.", loadsSeen, redirectsSeen);
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* hdl/LoadStoreUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module LoadStoreUnit import LsuOpPkg::*, SpecPkg::*; (
    input  logic        clk,
    input  logic        rst,

    input  logic        inValid,
    input  LsuOp        opcode,
    input  logic [31:0] srcA,
    input  logic [31:0] srcB,
    input  logic [31:0] imm,
    input  Tag          tagDst,
    input  RegName      nmDst,
    input  SqN          sqN,
    input  logic [31:0] pc,

    input  logic        invalidate,
    input  SqN          invalidateSqN,
    input  logic        commitValid,
    input  SqN          commitSqN,

    output logic        outValid,
    output Tag          outTagDst,
    output RegName      outNmDst,
    output SqN          outSqN,
    output logic [31:0] outResult,
    output logic        branchTaken,
    output logic [31:0] branchDstPc,
    output SqN          branchSqN,
    output logic        wbReq
);

    logic [29:0] memAddr;
    logic [31:0] memWriteData;
    logic [3:0]  memWriteMask;
    logic        memWriteEnable;
    logic        memReadEnable;
    logic [31:0] memReadData;

    logic        lbValid;
    logic        lbIsLoad;
    logic [31:0] lbAddr;
    SqN          lbSqN;
    logic        lbMispred;

    LSU LSU_inst (.*);

    LoadBuffer LoadBuffer_inst (
        .clk(clk), .rst(rst),
        .lbValid(lbValid), .lbIsLoad(lbIsLoad), .lbAddr(lbAddr), .lbSqN(lbSqN),
        .invalidate(invalidate), .invalidateSqN(invalidateSqN),
        .commitValid(commitValid), .commitSqN(commitSqN),
        .lbMispred(lbMispred)
    );

    DataMemory DataMemory_inst (
        .clk(clk),
        .memAddr(memAddr), .memWriteData(memWriteData), .memWriteMask(memWriteMask),
        .memWriteEnable(memWriteEnable), .memReadEnable(memReadEnable),
        .memReadData(memReadData)
    );

endmodule

`default_nettype wire

/* hdl/LSU.sv */
`timescale 1ns/100ps
`default_nettype none

module LSU import LsuOpPkg::*, SpecPkg::*; (
    input  logic        clk,
    input  logic        rst,

    input  logic        inValid,
    input  LsuOp        opcode,
    input  logic [31:0] srcA,
    input  logic [31:0] srcB,
    input  logic [31:0] imm,
    input  logic [31:0] pc,
    input  Tag          tagDst,
    input  RegName      nmDst,
    input  SqN          sqN,

    input  logic        invalidate,
    input  SqN          invalidateSqN,

    input  logic [31:0] memReadData,
    output logic [29:0] memAddr,
    output logic [31:0] memWriteData,
    output logic [3:0]  memWriteMask,
    output logic        memWriteEnable,
    output logic        memReadEnable,

    output logic        lbValid,
    output logic        lbIsLoad,
    output logic [31:0] lbAddr,
    output SqN          lbSqN,
    input  logic        lbMispred,

    output logic        wbReq,

    output logic        outValid,
    output Tag          outTagDst,
    output RegName      outNmDst,
    output SqN          outSqN,
    output logic [31:0] outResult,

    output logic        branchTaken,
    output logic [31:0] branchDstPc,
    output SqN          branchSqN
);

    logic [31:0] addr;
    logic [31:0] storeData;
    logic [3:0]  storeMask;
    logic        keepIn, keepMid, keepOut;

    logic        midValid;
    LsuOp        midOp;
    Tag          midTag;
    RegName      midNm;
    SqN          midSqN;
    logic [1:0]  midByte;
    logic [31:0] midPc;
    logic [31:0] outPc;

    logic [7:0]  laneByte;
    logic [15:0] laneHalf;
    logic [31:0] loadResult;

    assign addr = srcA + imm;

    // Survival under flush, one check per stage.
    assign keepIn  = inValid  && (!invalidate || isNotYounger(sqN, invalidateSqN));
    assign keepMid = midValid && (!invalidate || isNotYounger(midSqN, invalidateSqN));
    assign keepOut = outValid && (!invalidate || isNotYounger(outSqN, invalidateSqN));

    assign wbReq = keepMid; // Result lands next cycle.

    // Move store data into its byte lanes.
    always_comb begin
        storeData = srcB;
        storeMask = 4'b1111;
        case (opcode)
            LSU_SB: begin
                storeData = srcB << (8 * addr[1:0]);
                storeMask = 4'b0001 << addr[1:0];
            end
            LSU_SH: begin
                storeData = addr[1] ? (srcB << 16) : srcB;
                storeMask = addr[1] ? 4'b1100 : 4'b0011;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            midValid <= 1'b0;
            lbValid <= 1'b0;
            memReadEnable <= 1'b0;
            memWriteEnable <= 1'b0;
            outValid <= 1'b0;
            branchTaken <= 1'b0;
        end else begin
            midValid <= keepIn;
            lbValid <= keepIn;
            memReadEnable <= keepIn && isLoad(opcode);
            memWriteEnable <= keepIn && isStore(opcode);
            outValid <= keepMid;
            branchTaken <= keepOut && lbMispred; // Store hit a younger load.
        end
    end

    always_ff @(posedge clk) begin
        if (keepIn) begin
            midOp <= opcode;
            midTag <= tagDst;
            midNm <= nmDst;
            midSqN <= sqN;
            midByte <= addr[1:0];
            midPc <= pc;
            memAddr <= addr[31:2];
            memWriteData <= storeData;
            memWriteMask <= storeMask;
            lbIsLoad <= !isStore(opcode);
            lbAddr <= addr;
            lbSqN <= sqN;
        end
        if (keepMid) begin
            outTagDst <= midTag;
            outNmDst <= midNm;
            outSqN <= midSqN;
            outResult <= loadResult;
            outPc <= midPc;
        end
        if (keepOut) begin
            branchDstPc <= outPc + 32'd4;
            branchSqN <= outSqN;
        end
    end

    // Pick the addressed lane and extend it.
    always_comb begin
        laneByte = memReadData[8 * midByte +: 8];
        laneHalf = midByte[1] ? memReadData[31:16] : memReadData[15:0];
        case (midOp)
            LSU_LB:  loadResult = {{24{laneByte[7]}}, laneByte};
            LSU_LBU: loadResult = {24'b0, laneByte};
            LSU_LH:  loadResult = {{16{laneHalf[15]}}, laneHalf};
            LSU_LHU: loadResult = {16'b0, laneHalf};
            LSU_LW:  loadResult = memReadData;
            default: loadResult = 32'b0; // Stores write back nothing useful.
        endcase
    end

    assert property (@(posedge clk) disable iff (rst)
        memWriteEnable |-> !memReadEnable);

endmodule

`default_nettype wire

/* hdl/LoadBuffer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "lsu_settings.svh"

module LoadBuffer import SpecPkg::*; (
    input  logic        clk,
    input  logic        rst,

    input  logic        lbValid,
    input  logic        lbIsLoad,
    input  logic [31:0] lbAddr,
    input  SqN          lbSqN,

    input  logic        invalidate,
    input  SqN          invalidateSqN,

    input  logic        commitValid,
    input  SqN          commitSqN,

    output logic        lbMispred
);

    localparam int IdxW = $clog2(`LB_DEPTH);

    logic [`LB_DEPTH-1:0] entValid;
    logic [29:0]          entAddr [`LB_DEPTH];
    SqN                   entSqN  [`LB_DEPTH];

    logic [`LB_DEPTH-1:0] hitVec;
    logic [`LB_DEPTH-1:0] dropVec;
    logic                 freeFound;
    logic [IdxW-1:0]      freeIdx;
    logic                 insert;

    always_comb begin
        freeFound = 1'b0;
        freeIdx = '0;
        // Lowest free slot wins.
        for (int i = `LB_DEPTH - 1; i >= 0; i--) begin
            if (!entValid[i]) begin
                freeFound = 1'b1;
                freeIdx = IdxW'(i);
            end
        end
        for (int i = 0; i < `LB_DEPTH; i++) begin
            // A younger load to the same word already read stale data.
            hitVec[i] = entValid[i] && (entAddr[i] == lbAddr[31:2])
                && isOlder(lbSqN, entSqN[i]);
            dropVec[i] = (invalidate && !isNotYounger(entSqN[i], invalidateSqN))
                || (commitValid && isNotYounger(entSqN[i], commitSqN));
        end
    end

    assign insert = lbValid && lbIsLoad && freeFound;

    always_ff @(posedge clk) begin
        if (rst) begin
            entValid <= '0;
            lbMispred <= 1'b0;
        end else begin
            for (int i = 0; i < `LB_DEPTH; i++) begin
                if (dropVec[i])
                    entValid[i] <= 1'b0;
            end
            if (insert)
                entValid[freeIdx] <= 1'b1;
            lbMispred <= lbValid && !lbIsLoad && (|hitVec); // Lines up with the result.
        end
    end

    always_ff @(posedge clk) begin
        if (insert) begin
            entAddr[freeIdx] <= lbAddr[31:2];
            entSqN[freeIdx] <= lbSqN;
        end
    end

    // The issuer holds back loads so the table never overflows.
    assert property (@(posedge clk) disable iff (rst)
        (lbValid && lbIsLoad) |-> !(&entValid));

endmodule

`default_nettype wire

/* hdl/DataMemory.sv */
`timescale 1ns/100ps
`default_nettype none

`include "lsu_settings.svh"

module DataMemory (
    input  logic        clk,

    input  logic [29:0] memAddr,
    input  logic [31:0] memWriteData,
    input  logic [3:0]  memWriteMask,
    input  logic        memWriteEnable,
    input  logic        memReadEnable,

    output logic [31:0] memReadData
);

    localparam int IdxW = $clog2(`MEM_WORDS);

    logic [31:0]     mem [`MEM_WORDS];
    logic [IdxW-1:0] idx;

    assign idx = memAddr[IdxW-1:0]; // Address wraps at the memory size.

    initial begin
        for (int i = 0; i < `MEM_WORDS; i++)
            mem[i] = 32'b0;
    end

    always_ff @(posedge clk) begin
        if (memWriteEnable) begin
            for (int b = 0; b < 4; b++) begin
                if (memWriteMask[b])
                    mem[idx][8 * b +: 8] <= memWriteData[8 * b +: 8];
            end
        end
    end

    // Read is combinational from the registered address.
    assign memReadData = memReadEnable ? mem[idx] : 32'b0;

endmodule

`default_nettype wire

/* hdl/SpecPkg.sv */
`default_nettype none

package SpecPkg;

    typedef logic [5:0] SqN; // Wraps; age is judged by signed distance.

    // True when a is the same age as refSqN or older.
    function automatic logic isNotYounger(input SqN a, input SqN refSqN);
        SqN diff;
        diff = a - refSqN;
        return $signed(diff) <= 0;
    endfunction

    function automatic logic isOlder(input SqN a, input SqN refSqN);
        SqN diff;
        diff = a - refSqN;
        return $signed(diff) < 0;
    endfunction

endpackage

`default_nettype wire

/* hdl/LsuOpPkg.sv */
`default_nettype none

package LsuOpPkg;

    // Memory opcodes as they sit in the core's 6-bit opcode field.
    typedef enum logic [5:0] {
        LSU_LB  = 6'd0,
        LSU_LH  = 6'd1,
        LSU_LW  = 6'd2,
        LSU_LBU = 6'd3,
        LSU_LHU = 6'd4,
        LSU_SB  = 6'd5,
        LSU_SH  = 6'd6,
        LSU_SW  = 6'd7
    } LsuOp;

    typedef logic [4:0] RegName; // Architectural register.
    typedef logic [5:0] Tag;     // Physical destination tag.

    function automatic logic isStore(input LsuOp op);
        return (op == LSU_SB) || (op == LSU_SH) || (op == LSU_SW);
    endfunction

    function automatic logic isLoad(input LsuOp op);
        case (op)
            LSU_LB,
            LSU_LH,
            LSU_LW,
            LSU_LBU,
            LSU_LHU: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

endpackage

`default_nettype wire

/* hdl/lsu_settings.svh */
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// Executed loads that can wait for commit at one time.
`define LB_DEPTH 8

// Data memory size in 32-bit words. A power of two, so the word address
// wraps by dropping its upper bits.
`define MEM_WORDS 1024

`endif
